// File: rtl/trace_pkg.sv
package trace_pkg;

   // Simulation nop encoding, l.nop with a 16-bit immediate
   localparam logic [7:0] NOP_OPCODE = 8'h15;

   // Immediates that map to software events
   localparam logic [15:0] NOP_EXIT   = 16'd1;
   localparam logic [15:0] NOP_REPORT = 16'd2;
   localparam logic [15:0] NOP_PUTC   = 16'd4;

   // Register that carries the event argument
   localparam logic [4:0] ARG_REG = 5'd3;

   // Event queue sizing
   localparam int QUEUE_DEPTH = 4;
   localparam int QUEUE_PTR_W = 2;
   // Count needs one more bit to tell full from empty
   localparam int QUEUE_CNT_W = QUEUE_PTR_W + 1;

   // One retired instruction from the core writeback stage
   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [31:0] insn;
      logic        wben;
      logic [4:0]  wbreg;
      logic [31:0] wbdata;
   } trace_beat_t;

   // Beat after capture, r3 is the value before its own writeback
   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [31:0] insn;
      logic [31:0] r3;
   } stage_beat_t;

   // Software event kinds
   typedef enum logic [1:0] {
      EV_NONE,
      EV_EXIT,
      EV_REPORT,
      EV_PUTC
   } sw_event_e;

   typedef struct packed {
      sw_event_e   kind;
      logic [31:0] pc;
      logic [31:0] arg;
   } sw_event_t;

endpackage

// File: rtl/trace_capture.sv
`timescale 1ns/100ps

module trace_capture
   import trace_pkg::*;
(
   input  logic        clk,
   input  logic        rst_i,
   input  trace_beat_t trace_i,
   output stage_beat_t beat_o,
   output logic [31:0] insn_count_o
);

   stage_beat_t beat_q;
   logic [31:0] shadow_r3_q;
   logic [31:0] insn_count_q;
   logic        r3_write;

   // Only a retired beat may update the shadow copy
   assign r3_write = trace_i.valid && trace_i.wben && (trace_i.wbreg == ARG_REG);

   // Stage register
   always_ff @(posedge clk) begin
      if (rst_i) begin
         beat_q.valid <= 1'b0;
      end else begin
         beat_q.valid <= trace_i.valid;
      end
      beat_q.pc   <= trace_i.pc;
      beat_q.insn <= trace_i.insn;
      // r3 as seen before this beat writes it
      beat_q.r3   <= shadow_r3_q;
   end

   // Shadow r3 and retired instruction counter
   always_ff @(posedge clk) begin
      if (rst_i) begin
         shadow_r3_q  <= '0;
         insn_count_q <= '0;
      end else begin
         if (r3_write) begin
            shadow_r3_q <= trace_i.wbdata;
         end
         if (trace_i.valid) begin
            insn_count_q <= insn_count_q + 32'd1;
         end
      end
   end

   assign beat_o       = beat_q;
   assign insn_count_o = insn_count_q;

   // Core trace must be clean once out of reset
   a_valid_known : assert property (@(posedge clk) disable iff (rst_i)
      !$isunknown(trace_i.valid))
      else $error("trace valid is unknown");

endmodule

// File: rtl/nop_decoder.sv
`timescale 1ns/100ps

module nop_decoder
   import trace_pkg::*;
(
   input  logic        clk,
   input  logic        rst_i,
   input  stage_beat_t beat_i,
   output sw_event_t   event_o
);

   sw_event_e kind_d;
   sw_event_t event_q;
   logic      is_nop;

   // Opcode field of l.nop
   assign is_nop = beat_i.valid && (beat_i.insn[31:24] == NOP_OPCODE);

   // Immediate selects the event kind
   always_comb begin
      kind_d = EV_NONE;
      if (is_nop) begin
         case (beat_i.insn[15:0])
            NOP_EXIT: begin
               kind_d = EV_EXIT;
            end
            NOP_REPORT: begin
               kind_d = EV_REPORT;
            end
            NOP_PUTC: begin
               kind_d = EV_PUTC;
            end
            // Other immediates are plain nops
            default: begin
               kind_d = EV_NONE;
            end
         endcase
      end
   end

   // Event record, kind is the only control field
   always_ff @(posedge clk) begin
      if (rst_i) begin
         event_q.kind <= EV_NONE;
      end else begin
         event_q.kind <= kind_d;
      end
      event_q.pc  <= beat_i.pc;
      // Argument is r3 ahead of this instruction
      event_q.arg <= beat_i.r3;
   end

   assign event_o = event_q;

endmodule

// File: rtl/event_queue.sv
`timescale 1ns/100ps

module event_queue
   import trace_pkg::*;
(
   input  logic      clk,
   input  logic      rst_i,
   input  sw_event_t push_event_i,
   input  logic      pop_i,
   output sw_event_t head_o,
   output logic      empty_o,
   output logic      overflow_o
);

   sw_event_t              mem_q [QUEUE_DEPTH];
   logic [QUEUE_PTR_W-1:0] wr_ptr_q;
   logic [QUEUE_PTR_W-1:0] rd_ptr_q;
   logic [QUEUE_CNT_W-1:0] count_q;
   logic                   overflow_q;
   logic                   has_event;
   logic                   full;
   logic                   push;
   logic                   drop;

   assign has_event = (push_event_i.kind != EV_NONE);
   assign full      = (count_q == QUEUE_CNT_W'(QUEUE_DEPTH));
   // Trace cannot stall, so a full queue loses the event
   assign push      = has_event && !full;
   assign drop      = has_event && full;

   // Storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem_q[wr_ptr_q] <= push_event_i;
      end
   end

   // Pointers wrap since depth is a power of two
   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         overflow_q <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         // Sticky until reset
         if (drop) begin
            overflow_q <= 1'b1;
         end
      end
   end

   assign head_o     = mem_q[rd_ptr_q];
   assign empty_o    = (count_q == '0);
   assign overflow_o = overflow_q;

   // Sender must only pop a filled queue
   a_no_pop_empty : assert property (@(posedge clk) disable iff (rst_i)
      pop_i |-> !empty_o)
      else $error("pop from empty event queue");

endmodule

// File: rtl/event_sender.sv
`timescale 1ns/100ps

module event_sender
   import trace_pkg::*;
(
   input  logic        clk,
   input  logic        rst_i,
   input  sw_event_t   head_i,
   input  logic        empty_i,
   output logic        pop_o,
   output sw_event_t   event_o,
   output logic        event_req_o,
   input  logic        event_ack_i,
   output logic        terminated_o,
   output logic [31:0] exit_code_o
);

   typedef enum logic [1:0] {
      IDLE,
      LOAD,
      REQ,
      WAIT_ACK_LOW
   } state_e;

   state_e      state_q;
   sw_event_t   event_q;
   logic        terminated_q;
   logic [31:0] exit_code_q;

   // Pop one cycle after seeing data while idle
   assign pop_o = (state_q == LOAD);

   // Head latched on the pop and held for the whole request
   always_ff @(posedge clk) begin
      if (pop_o) begin
         event_q <= head_i;
      end
   end

   // Four-phase handshake FSM
   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q      <= IDLE;
         terminated_q <= 1'b0;
         exit_code_q  <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               if (!empty_i) begin
                  state_q <= LOAD;
               end
            end
            LOAD: begin
               state_q <= REQ;
            end
            REQ: begin
               if (event_ack_i) begin
                  state_q <= WAIT_ACK_LOW;
                  // Exit counts once the host has taken it
                  if (event_q.kind == EV_EXIT) begin
                     terminated_q <= 1'b1;
                     exit_code_q  <= event_q.arg;
                  end
               end
            end
            WAIT_ACK_LOW: begin
               if (!event_ack_i) begin
                  state_q <= IDLE;
               end
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   assign event_req_o  = (state_q == REQ);
   assign event_o      = event_q;
   assign terminated_o = terminated_q;
   assign exit_code_o  = exit_code_q;

   // Payload must hold across a pending request
   a_event_stable : assert property (@(posedge clk) disable iff (rst_i)
      $past(event_req_o) && event_req_o |-> $stable(event_o))
      else $error("event changed while request pending");

endmodule

// File: rtl/trace_monitor_top.sv
`timescale 1ns/100ps

module trace_monitor_top
   import trace_pkg::*;
(
   input  logic        clk,
   input  logic        rst_i,
   input  trace_beat_t trace_i,
   output sw_event_t   event_o,
   output logic        event_req_o,
   input  logic        event_ack_i,
   output logic        terminated_o,
   output logic [31:0] exit_code_o,
   output logic        overflow_o,
   output logic [31:0] insn_count_o
);

   // Stage links
   stage_beat_t s1_beat;
   sw_event_t   s2_event;
   sw_event_t   q_head;
   logic        q_empty;
   logic        q_pop;

   // Stage 1, capture and shadow r3
   trace_capture trace_capture_inst (
      .clk          (clk),
      .rst_i        (rst_i),
      .trace_i      (trace_i),
      .beat_o       (s1_beat),
      .insn_count_o (insn_count_o)
   );

   // Stage 2, nop decode
   nop_decoder nop_decoder_inst (
      .clk     (clk),
      .rst_i   (rst_i),
      .beat_i  (s1_beat),
      .event_o (s2_event)
   );

   // Stage 3, buffering
   event_queue event_queue_inst (
      .clk          (clk),
      .rst_i        (rst_i),
      .push_event_i (s2_event),
      .pop_i        (q_pop),
      .head_o       (q_head),
      .empty_o      (q_empty),
      .overflow_o   (overflow_o)
   );

   // Host handshake and termination
   event_sender event_sender_inst (
      .clk          (clk),
      .rst_i        (rst_i),
      .head_i       (q_head),
      .empty_i      (q_empty),
      .pop_o        (q_pop),
      .event_o      (event_o),
      .event_req_o  (event_req_o),
      .event_ack_i  (event_ack_i),
      .terminated_o (terminated_o),
      .exit_code_o  (exit_code_o)
   );

endmodule

// File: verification/tb_trace_model.svh
`ifndef TB_TRACE_MODEL_SVH
`define TB_TRACE_MODEL_SVH

// Reference copy of the architectural r3
logic [31:0] model_r3;
// Retired beats seen so far
int unsigned model_count;
// Events the DUT still owes, oldest first
sw_event_t   exp_q[$];

// Map a simulation nop immediate to its software event
function automatic sw_event_e expected_kind(input logic [15:0] imm);
   sw_event_e kind;
   kind = EV_NONE;
   if (imm == NOP_EXIT) begin
      kind = EV_EXIT;
   end else if (imm == NOP_REPORT) begin
      kind = EV_REPORT;
   end else if (imm == NOP_PUTC) begin
      kind = EV_PUTC;
   end
   return kind;
endfunction

task automatic model_reset();
   model_r3    = '0;
   model_count = 0;
   exp_q.delete();
endtask

// Apply one trace beat to the model
task automatic model_beat(input trace_beat_t b);
   sw_event_t ev;
   if (b.valid) begin
      model_count++;
      // Argument is r3 ahead of the beat's own writeback
      if ((b.insn[31:24] == NOP_OPCODE) && (expected_kind(b.insn[15:0]) != EV_NONE)) begin
         ev.kind = expected_kind(b.insn[15:0]);
         ev.pc   = b.pc;
         ev.arg  = model_r3;
         exp_q.push_back(ev);
      end
      if (b.wben && (b.wbreg == ARG_REG)) begin
         model_r3 = b.wbdata;
      end
   end
endtask

`endif

// File: verification/tb_trace_monitor.sv
`timescale 1ns/100ps

module tb_trace_monitor
   import trace_pkg::*;
();

   logic        clk;
   logic        rst_i;
   trace_beat_t trace_i;
   sw_event_t   event_o;
   logic        event_req_o;
   logic        event_ack_i = 1'b0;
   logic        terminated_o;
   logic [31:0] exit_code_o;
   logic        overflow_o;
   logic [31:0] insn_count_o;

   int          errors = 0;
   int          checks = 0;
   // Responder keeps ack low while set
   logic        hold_ack = 1'b0;
   logic        prev_req = 1'b0;
   sw_event_t   prev_event;
   int          ack_delay = -1;

   `include "tb_trace_model.svh"

   trace_monitor_top trace_monitor_top_inst (
      .clk          (clk),
      .rst_i        (rst_i),
      .trace_i      (trace_i),
      .event_o      (event_o),
      .event_req_o  (event_req_o),
      .event_ack_i  (event_ack_i),
      .terminated_o (terminated_o),
      .exit_code_o  (exit_code_o),
      .overflow_o   (overflow_o),
      .insn_count_o (insn_count_o)
   );

   // 8 ns clock
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
      checks++;
      if (actual !== expected) begin
         $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
         errors++;
      end
   endtask

   // Compare a delivered event with the oldest model event
   task automatic check_event(input sw_event_t got);
      sw_event_t exp;
      if (exp_q.size() == 0) begin
         $display("At %0t an event was delivered that the model did not expect, pc %h",
                  $time, got.pc);
         errors++;
      end else begin
         exp = exp_q.pop_front();
         check_value("event_o.kind", exp.kind, got.kind);
         check_value("event_o.pc", exp.pc, got.pc);
         check_value("event_o.arg", exp.arg, got.arg);
      end
   endtask

   // Protocol checks come before the host side of the handshake
   always @(posedge clk) begin
      #1;
      if (!rst_i) begin
         if (event_req_o && !prev_req) begin
            if (event_ack_i) begin
               $display("At %0t the request rose while ack was still high", $time);
               errors++;
            end
            check_event(event_o);
         end
         if (event_req_o && prev_req) begin
            check_value("event_o", prev_event, event_o);
         end
         if (event_ack_i) begin
            // Phase 4 release a few cycles after req has dropped
            if (!event_req_o) begin
               if (ack_delay < 0) begin
                  ack_delay = $urandom_range(3, 0);
               end
               if (ack_delay == 0) begin
                  event_ack_i = 1'b0;
                  ack_delay   = -1;
               end else begin
                  ack_delay--;
               end
            end
         end else if (event_req_o && !hold_ack) begin
            if (ack_delay < 0) begin
               ack_delay = $urandom_range(3, 0);
            end
            if (ack_delay == 0) begin
               event_ack_i = 1'b1;
               ack_delay   = -1;
            end else begin
               ack_delay--;
            end
         end
      end
      prev_req   = event_req_o;
      prev_event = event_o;
   end

   // One beat driven just after the edge
   task automatic drive_beat(input trace_beat_t b);
      @(posedge clk);
      #1;
      trace_i = b;
      model_beat(b);
   endtask

   task automatic drive_idle(input int cycles);
      repeat (cycles) drive_beat('0);
   endtask

   // Ordinary instruction that never uses the nop opcode
   function automatic trace_beat_t random_beat();
      trace_beat_t b;
      b.valid  = 1'b1;
      b.pc     = $urandom;
      b.insn   = $urandom;
      if (b.insn[31:24] == NOP_OPCODE) begin
         b.insn[31:24] = 8'h00;
      end
      b.wben   = 1'($urandom_range(1, 0));
      // r3 gets about half of the writebacks
      b.wbreg  = ($urandom_range(1, 0) == 1) ? ARG_REG : 5'($urandom);
      b.wbdata = $urandom;
      return b;
   endfunction

   function automatic trace_beat_t nop_beat(input logic [15:0] imm);
      trace_beat_t b;
      b        = '0;
      b.valid  = 1'b1;
      b.pc     = $urandom;
      b.insn   = {NOP_OPCODE, 8'h00, imm};
      return b;
   endfunction

   // Report or putc only since exit is saved for the last test
   function automatic logic [15:0] event_imm();
      return ($urandom_range(1, 0) == 1) ? NOP_PUTC : NOP_REPORT;
   endfunction

   // Any immediate that is not an event
   function automatic logic [15:0] plain_imm();
      logic [15:0] imm;
      imm = 16'($urandom_range(15, 0));
      if ((imm == NOP_EXIT) || (imm == NOP_REPORT) || (imm == NOP_PUTC)) begin
         imm = imm | 16'h0100;
      end
      return imm;
   endfunction

   // Until every model event is out and the handshake is back at rest
   task automatic wait_drained();
      int n;
      n = 0;
      while ((exp_q.size() != 0) || event_req_o || event_ack_i) begin
         if (n == 1000) begin
            $display("Timed out at %0t waiting for %0d events to be delivered",
                     $time, exp_q.size());
            errors++;
            break;
         end
         drive_idle(1);
         n++;
      end
   endtask

   task automatic check_count();
      drive_idle(2);
      check_value("insn_count_o", model_count, insn_count_o);
   endtask

   initial begin
      trace_beat_t b;
      logic [31:0] code;
      int          gap;
      void'($urandom(32'h55d6e159));
      rst_i   = 1'b1;
      trace_i = '0;
      model_reset();
      repeat (5) @(posedge clk);
      #1;
      rst_i = 1'b0;
      check_value("event_req_o", 0, event_req_o);
      check_value("terminated_o", 0, terminated_o);
      check_value("exit_code_o", 0, exit_code_o);
      check_value("overflow_o", 0, overflow_o);
      check_value("insn_count_o", 0, insn_count_o);

      // Spaced events checked for content and order
      for (int i = 0; i < 40; i++) begin
         gap = $urandom_range(4, 0);
         for (int j = 0; j < gap; j++) begin
            drive_beat(random_beat());
         end
         drive_beat(nop_beat(event_imm()));
         drive_idle(12);
      end
      wait_drained();
      check_value("expected events left", 0, exp_q.size());
      check_count();

      // Burst with no events
      for (int i = 0; i < 30; i++) begin
         if ($urandom_range(1, 0) == 1) begin
            drive_beat(random_beat());
         end else begin
            drive_beat(nop_beat(plain_imm()));
         end
      end
      for (int i = 0; i < 20; i++) begin
         drive_idle(1);
         check_value("event_req_o", 0, event_req_o);
      end
      check_count();

      // Overflow with the host stalled
      check_value("overflow_o", 0, overflow_o);
      hold_ack = 1'b1;
      for (int k = 0; k < 8; k++) begin
         b        = nop_beat(event_imm());
         b.wben   = 1'b1;
         b.wbreg  = ARG_REG;
         b.wbdata = $urandom;
         drive_beat(b);
         // Beyond sender plus queue the event is lost
         if (k >= QUEUE_DEPTH + 1) begin
            void'(exp_q.pop_back());
         end
      end
      drive_idle(10);
      check_value("overflow_o", 1, overflow_o);
      hold_ack = 1'b0;
      wait_drained();
      drive_idle(20);
      check_value("expected events left", 0, exp_q.size());
      check_count();

      // Exit with a known code
      check_value("terminated_o", 0, terminated_o);
      b       = random_beat();
      b.wben  = 1'b1;
      b.wbreg = ARG_REG;
      code    = b.wbdata;
      drive_beat(b);
      drive_beat(nop_beat(NOP_EXIT));
      wait_drained();
      drive_idle(2);
      check_value("terminated_o", 1, terminated_o);
      check_value("exit_code_o", code, exit_code_o);
      check_count();

      $display("Errors: %0d in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: flist.f
+incdir+verification
rtl/trace_pkg.sv
rtl/trace_capture.sv
rtl/nop_decoder.sv
rtl/event_queue.sv
rtl/event_sender.sv
rtl/trace_monitor_top.sv
verification/tb_trace_monitor.sv

// File: Makefile
SIM  := obj_dir/Vtb_trace_monitor
SRCS := $(filter %.sv,$(shell cat flist.f)) $(wildcard verification/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_trace_monitor -f flist.f

# Pass only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
		echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
